//--- clint_sys.f
hw/clint_pkg.sv
hw/clint_bus_fsm.sv
hw/clint_mtime_counter.sv
hw/clint_cmp_irq.sv
hw/clint_top.sv
tb/clint_tb_clock.sv
tb/clint_tb.sv

//--- hw/clint_bus_fsm.sv
`timescale 1ns/1ps

module clint_bus_fsm #(
    parameter int NUM_HARTS = 2
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               aw_valid,
    input  clint_pkg::axi_aw_t                 aw,
    output logic                               aw_ready,
    input  logic                               w_valid,
    input  clint_pkg::axi_w_t                  w,
    output logic                               w_ready,
    output logic                               b_valid,
    output clint_pkg::axi_resp_e               b_resp,
    input  logic                               b_ready,
    input  logic                               ar_valid,
    input  logic [clint_pkg::ADDR_W-1:0]       ar_addr,
    output logic                               ar_ready,
    output logic                               r_valid,
    output clint_pkg::axi_r_t                  r,
    input  logic                               r_ready,
    output clint_pkg::reg_req_t                reg_req,
    input  clint_pkg::word_t                   mtime,
    input  clint_pkg::word_t                   cmp_rdata
);

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WRESP,
        BUS_RDATA
    } bus_state_e;

    typedef struct packed {
        clint_pkg::reg_sel_e             sel;
        logic [clint_pkg::HART_W-1:0]    hart;
    } dec_t;

    bus_state_e                     state;
    logic                           wr_go;
    logic                           rd_go;
    logic [clint_pkg::ADDR_W-1:0]   dec_addr;
    dec_t                           dec;
    clint_pkg::word_t               rd_data;
    clint_pkg::axi_resp_e           dec_resp;

    // mtime at its fixed slot, mtimecmp as an aligned array of NUM_HARTS words
    function automatic dec_t decode_addr(input logic [clint_pkg::ADDR_W-1:0] addr);
        dec_t                           d;
        logic [clint_pkg::ADDR_W-1:0]   off;
        logic [clint_pkg::ADDR_W-4:0]   idx;
        d.sel  = clint_pkg::SEL_NONE;
        d.hart = '0;
        off    = addr - clint_pkg::MTIMECMP_BASE;
        idx    = off[clint_pkg::ADDR_W-1:3];
        if (addr == clint_pkg::MTIME_OFFSET)
        begin
            d.sel = clint_pkg::SEL_MTIME;
        end
        else if (addr >= clint_pkg::MTIMECMP_BASE && addr < clint_pkg::MTIME_OFFSET &&
                 off[2:0] == 3'b000 && idx < NUM_HARTS)
        begin
            d.sel  = clint_pkg::SEL_MTIMECMP;
            d.hart = idx[clint_pkg::HART_W-1:0];
        end
        return d;
    endfunction

    // write beats a read, nothing is accepted while a response waits
    assign wr_go = (state == BUS_IDLE) && aw_valid && w_valid;
    assign rd_go = (state == BUS_IDLE) && ar_valid && !aw_valid && !w_valid;

    assign aw_ready = wr_go;
    assign w_ready  = wr_go;
    assign ar_ready = rd_go;

    assign dec_addr = wr_go ? aw.addr : ar_addr;
    assign dec      = decode_addr(dec_addr);
    assign dec_resp = (dec.sel == clint_pkg::SEL_NONE) ? clint_pkg::AXI_SLVERR
                                                       : clint_pkg::AXI_OKAY;

    always_comb
    begin
        reg_req.op    = wr_go ? clint_pkg::OP_WRITE :
                        rd_go ? clint_pkg::OP_READ  : clint_pkg::OP_IDLE;
        reg_req.sel   = dec.sel;
        reg_req.hart  = dec.hart;
        reg_req.wdata = w.data;
        reg_req.wstrb = w.strb;
    end

    always_comb
    begin
        case (dec.sel)
            clint_pkg::SEL_MTIME:    rd_data = mtime;
            clint_pkg::SEL_MTIMECMP: rd_data = cmp_rdata;
            default:                 rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= BUS_IDLE;
        end
        else
        begin
            case (state)
                BUS_IDLE:
                begin
                    if (wr_go)
                        state <= BUS_WRESP;
                    else if (rd_go)
                        state <= BUS_RDATA;
                end
                BUS_WRESP:
                begin
                    if (b_ready)
                        state <= BUS_IDLE;
                end
                BUS_RDATA:
                begin
                    if (r_ready)
                        state <= BUS_IDLE;
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // response payload is loaded once at the handshake and held until taken
    always_ff @(posedge clk)
    begin
        if (wr_go)
            b_resp <= dec_resp;
        if (rd_go)
        begin
            r.data <= rd_data;
            r.resp <= dec_resp;
        end
    end

    assign b_valid = (state == BUS_WRESP);
    assign r_valid = (state == BUS_RDATA);

endmodule

//--- hw/clint_cmp_irq.sv
`timescale 1ns/1ps

module clint_cmp_irq #(
    parameter int NUM_HARTS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  clint_pkg::reg_req_t   reg_req,
    input  clint_pkg::word_t      mtime,
    output clint_pkg::word_t      cmp_rdata,
    output logic [NUM_HARTS-1:0]  timer_irq
);

    clint_pkg::word_t       mtimecmp [NUM_HARTS];
    logic [NUM_HARTS-1:0]   cmp_hit;
    logic [NUM_HARTS-1:0]   hit_q0;
    logic [NUM_HARTS-1:0]   hit_q1;
    logic                   wr_hit;

    assign wr_hit = (reg_req.op == clint_pkg::OP_WRITE) &&
                    (reg_req.sel == clint_pkg::SEL_MTIMECMP);

    // all ones keeps every hart quiet until software programs a deadline
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int h = 0; h < NUM_HARTS; h++)
                mtimecmp[h] <= '1;
        end
        else if (wr_hit)
        begin
            for (int h = 0; h < NUM_HARTS; h++)
            begin
                if (reg_req.hart == h)
                    mtimecmp[h] <= clint_pkg::apply_strb(mtimecmp[h], reg_req.wdata,
                                                         reg_req.wstrb);
            end
        end
    end

    // read mux gives zero when the request is not aimed at a compare register
    always_comb
    begin
        cmp_rdata = '0;
        if (reg_req.sel == clint_pkg::SEL_MTIMECMP)
        begin
            for (int h = 0; h < NUM_HARTS; h++)
            begin
                if (reg_req.hart == h)
                    cmp_rdata = mtimecmp[h];
            end
        end
    end

    always_comb
    begin
        for (int h = 0; h < NUM_HARTS; h++)
            cmp_hit[h] = (mtime >= mtimecmp[h]);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hit_q0 <= '0;
            hit_q1 <= '0;
        end
        else
        begin
            hit_q0 <= cmp_hit;
            hit_q1 <= hit_q0;
        end
    end

    // rising edge of the registered compare gives a single-cycle pulse
    assign timer_irq = hit_q0 & ~hit_q1;

endmodule

//--- hw/clint_mtime_counter.sv
`timescale 1ns/1ps

module clint_mtime_counter #(
    parameter int TICK_DIV = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  clint_pkg::reg_req_t  reg_req,
    output clint_pkg::word_t     mtime
);

    // at least one bit so TICK_DIV of 1 still elaborates
    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0] pre_cnt;
    logic             tick;
    logic             wr_hit;

    assign tick   = (pre_cnt == PRE_W'(TICK_DIV - 1));
    assign wr_hit = (reg_req.op == clint_pkg::OP_WRITE) &&
                    (reg_req.sel == clint_pkg::SEL_MTIME);

    // prescaler runs freely, a write to mtime does not restart it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pre_cnt <= '0;
        else if (tick)
            pre_cnt <= '0;
        else
            pre_cnt <= pre_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime <= '0;
        end
        else if (wr_hit)
        begin
            // software write replaces this cycle's increment
            mtime <= clint_pkg::apply_strb(mtime, reg_req.wdata, reg_req.wstrb);
        end
        else if (tick)
        begin
            mtime <= mtime + 1'b1;
        end
    end

endmodule

//--- hw/clint_pkg.sv
package clint_pkg;

    // bus and register widths
    localparam int DATA_W = 64;
    localparam int ADDR_W = 16;
    localparam int STRB_W = DATA_W / 8;
    localparam int HART_W = 8;

    // register offsets within the 64 KiB window
    localparam logic [ADDR_W-1:0] MTIMECMP_BASE = 16'h4000;
    localparam logic [ADDR_W-1:0] MTIME_OFFSET  = 16'hBFF8;

    typedef logic [DATA_W-1:0] word_t;

    typedef enum logic [1:0] {
        AXI_OKAY   = 2'd0,
        AXI_SLVERR = 2'd2
    } axi_resp_e;

    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_MTIME,
        SEL_MTIMECMP
    } reg_sel_e;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_WRITE,
        OP_READ
    } reg_op_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        word_t             data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        word_t     data;
        axi_resp_e resp;
    } axi_r_t;

    // one request per cycle from the bus side to the register blocks
    typedef struct packed {
        reg_op_e           op;
        reg_sel_e          sel;
        logic [HART_W-1:0] hart;
        word_t             wdata;
        logic [STRB_W-1:0] wstrb;
    } reg_req_t;

    // byte lanes with a set strobe take the new data
    function automatic word_t apply_strb(
        input word_t             old_val,
        input word_t             new_val,
        input logic [STRB_W-1:0] strb
    );
        word_t res;
        res = old_val;
        for (int i = 0; i < STRB_W; i++)
        begin
            if (strb[i])
                res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

endpackage

//--- hw/clint_top.sv
`timescale 1ns/1ps

module clint_top #(
    parameter int NUM_HARTS = 2,
    parameter int TICK_DIV  = 1
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               aw_valid,
    input  clint_pkg::axi_aw_t                 aw,
    output logic                               aw_ready,
    input  logic                               w_valid,
    input  clint_pkg::axi_w_t                  w,
    output logic                               w_ready,
    output logic                               b_valid,
    output clint_pkg::axi_resp_e               b_resp,
    input  logic                               b_ready,
    input  logic                               ar_valid,
    input  logic [clint_pkg::ADDR_W-1:0]       ar_addr,
    output logic                               ar_ready,
    output logic                               r_valid,
    output clint_pkg::axi_r_t                  r,
    input  logic                               r_ready,
    output logic [NUM_HARTS-1:0]               timer_irq
);

    clint_pkg::reg_req_t reg_req;
    clint_pkg::word_t    mtime;
    clint_pkg::word_t    cmp_rdata;

    // AXI4-Lite slave and register decode
    clint_bus_fsm #(
        .NUM_HARTS (NUM_HARTS)
    ) bus_fsm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_valid  (aw_valid),
        .aw        (aw),
        .aw_ready  (aw_ready),
        .w_valid   (w_valid),
        .w         (w),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .b_resp    (b_resp),
        .b_ready   (b_ready),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .reg_req   (reg_req),
        .mtime     (mtime),
        .cmp_rdata (cmp_rdata)
    );

    clint_mtime_counter #(
        .TICK_DIV (TICK_DIV)
    ) mtime_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .reg_req (reg_req),
        .mtime   (mtime)
    );

    // per-hart compare registers and interrupt pulses
    clint_cmp_irq #(
        .NUM_HARTS (NUM_HARTS)
    ) cmp_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_req   (reg_req),
        .mtime     (mtime),
        .cmp_rdata (cmp_rdata),
        .timer_irq (timer_irq)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the CLINT testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module clint_tb -f clint_sys.f -o clint_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/clint_sim > sim.log 2>&1
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- tb/clint_tb.sv
`timescale 1ns/1ps

module clint_tb;

    localparam int NUM_HARTS = 2;
    localparam int TICK_DIV  = 2;
    localparam int TIMEOUT   = 200;

    logic                         clk;
    logic                         rst_n;
    logic                         aw_valid;
    clint_pkg::axi_aw_t           aw;
    logic                         aw_ready;
    logic                         w_valid;
    clint_pkg::axi_w_t            w;
    logic                         w_ready;
    logic                         b_valid;
    clint_pkg::axi_resp_e         b_resp;
    logic                         b_ready;
    logic                         ar_valid;
    logic [clint_pkg::ADDR_W-1:0] ar_addr;
    logic                         ar_ready;
    logic                         r_valid;
    clint_pkg::axi_r_t            r;
    logic                         r_ready;
    logic [NUM_HARTS-1:0]         timer_irq;

    logic [15:0]                  lfsr_q;
    longint unsigned              cyc;
    int                           pulse_cnt [NUM_HARTS];
    logic [NUM_HARTS-1:0]         irq_prev;
    clint_pkg::word_t             cmp_model [NUM_HARTS];

    clint_tb_clock clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    clint_top #(
        .NUM_HARTS (NUM_HARTS),
        .TICK_DIV  (TICK_DIV)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_valid  (aw_valid),
        .aw        (aw),
        .aw_ready  (aw_ready),
        .w_valid   (w_valid),
        .w         (w),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .b_resp    (b_resp),
        .b_ready   (b_ready),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .timer_irq (timer_irq)
    );

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with one shift per bit handed out
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic clint_pkg::word_t merge_bytes(input clint_pkg::word_t old_val,
                                                     input clint_pkg::word_t new_val,
                                                     input logic [7:0] strb);
        clint_pkg::word_t mask;
        for (int i = 0; i < 8; i++)
            mask[8*i +: 8] = {8{strb[i]}};
        return (new_val & mask) | (old_val & ~mask);
    endfunction

    // only mtime and the aligned mtimecmp slots of existing harts answer OKAY
    function automatic clint_pkg::axi_resp_e decode_ok(input logic [15:0] addr);
        int off;
        off = int'(addr) - int'(clint_pkg::MTIMECMP_BASE);
        if (addr == clint_pkg::MTIME_OFFSET)
            return clint_pkg::AXI_OKAY;
        if (off >= 0 && off < 8 * NUM_HARTS && off % 8 == 0)
            return clint_pkg::AXI_OKAY;
        return clint_pkg::AXI_SLVERR;
    endfunction

    function automatic logic [NUM_HARTS-1:0] pulses_above(input int limit);
        logic [NUM_HARTS-1:0] v;
        for (int k = 0; k < NUM_HARTS; k++)
            v[k] = (pulse_cnt[k] > limit);
        return v;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic hang(input string chan);
        fail_now($sformatf("timeout: the %s channel never completed its handshake", chan));
    endtask

    task automatic check_word(input clint_pkg::word_t got, input clint_pkg::word_t exp,
                              input string what);
        if (got !== exp)
            fail_now($sformatf("mismatch at time %0d: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    task automatic check_range(input clint_pkg::word_t got, input clint_pkg::word_t lo,
                               input clint_pkg::word_t hi, input string what);
        if (got < lo || got > hi)
            fail_now($sformatf("mismatch at time %0d: %s is %h, expected %h to %h",
                               $time, what, got, lo, hi));
    endtask

    task automatic check_resp(input clint_pkg::axi_resp_e got, input clint_pkg::axi_resp_e exp,
                              input string what);
        if (got !== exp)
            fail_now($sformatf("mismatch at time %0d: %s is %0d, expected %s",
                               $time, what, got, exp.name()));
    endtask

    task automatic check_irq(input logic [NUM_HARTS-1:0] got, input logic [NUM_HARTS-1:0] exp,
                             input string what);
        if (got !== exp)
            fail_now($sformatf("mismatch at time %0d: %s is %b, expected %b",
                               $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            fail_now($sformatf("mismatch at time %0d: %s is %b, expected %b",
                               $time, what, got, exp));
    endtask

    // every task starts and ends 1 ns after a rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // an unmapped write parked behind a read response goes through once the slave is idle
    task automatic finish_queued_write();
        int n;
        n = 0;
        #1;
        while (!(aw_ready && w_ready))
        begin
            n++;
            if (n > TIMEOUT)
                hang("queued write address and data");
            @(posedge clk);
            #2;
        end
        step();
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        n = 0;
        while (!b_valid)
        begin
            n++;
            if (n > TIMEOUT)
                hang("queued write response");
            step();
        end
        check_resp(b_resp, decode_ok(16'h0000), "queued write response");
        b_ready = 1'b1;
        step();
        b_ready = 1'b0;
    endtask

    task automatic axi_write(input logic [15:0] addr, input clint_pkg::word_t data,
                             input logic [7:0] strb, output clint_pkg::axi_resp_e resp);
        int                   n;
        int                   delay;
        clint_pkg::axi_resp_e first;
        clint_pkg::word_t     rd_val;
        clint_pkg::axi_resp_e rd_resp;
        aw_valid = 1'b1;
        aw.addr  = addr;
        w_valid  = 1'b1;
        w.data   = data;
        w.strb   = strb;
        n = 0;
        #1;
        while (!(aw_ready && w_ready))
        begin
            n++;
            if (n > TIMEOUT)
                hang("write address and data");
            @(posedge clk);
            #2;
        end
        step();
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        n = 0;
        while (!b_valid)
        begin
            n++;
            if (n > TIMEOUT)
                hang("write response");
            step();
        end
        first = b_resp;
        delay = int'(rand_bits(2));
        // a read queued behind the write response has to wait for it
        ar_valid = 1'b1;
        ar_addr  = clint_pkg::MTIME_OFFSET;
        for (int i = 0; i < delay; i++)
        begin
            step();
            check_bit(b_valid, 1'b1, "b_valid under back-pressure");
            check_resp(b_resp, first, "b_resp under back-pressure");
            check_bit(aw_ready | w_ready | ar_ready, 1'b0, "ready while a response waits");
        end
        b_ready = 1'b1;
        step();
        b_ready = 1'b0;
        resp = first;
        axi_read(clint_pkg::MTIME_OFFSET, rd_val, rd_resp);
        check_resp(rd_resp, clint_pkg::AXI_OKAY, "queued mtime read response");
    endtask

    task automatic axi_read(input logic [15:0] addr, output clint_pkg::word_t data,
                            output clint_pkg::axi_resp_e resp);
        int                   n;
        int                   delay;
        clint_pkg::word_t     first_data;
        clint_pkg::axi_resp_e first_resp;
        ar_valid = 1'b1;
        ar_addr  = addr;
        n = 0;
        #1;
        while (!ar_ready)
        begin
            n++;
            if (n > TIMEOUT)
                hang("read address");
            @(posedge clk);
            #2;
        end
        step();
        ar_valid = 1'b0;
        n = 0;
        while (!r_valid)
        begin
            n++;
            if (n > TIMEOUT)
                hang("read data");
            step();
        end
        first_data = r.data;
        first_resp = r.resp;
        delay = int'(rand_bits(2));
        // an unmapped write queued behind the read data has to wait for it
        aw_valid = 1'b1;
        aw.addr  = 16'h0000;
        w_valid  = 1'b1;
        w.data   = '0;
        w.strb   = 8'hFF;
        for (int i = 0; i < delay; i++)
        begin
            step();
            check_bit(r_valid, 1'b1, "r_valid under back-pressure");
            check_word(r.data, first_data, "r.data under back-pressure");
            check_resp(r.resp, first_resp, "r.resp under back-pressure");
            check_bit(aw_ready | w_ready | ar_ready, 1'b0, "ready while a response waits");
        end
        r_ready = 1'b1;
        step();
        r_ready = 0;
        data = first_data;
        resp = first_resp;
        finish_queued_write();
    endtask

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // timer_irq is sampled mid-cycle and each pulse must be one cycle wide
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            check_irq(timer_irq & irq_prev, '0, "timer_irq held for two cycles");
            for (int k = 0; k < NUM_HARTS; k++)
                pulse_cnt[k] += int'(timer_irq[k]);
        end
        irq_prev = timer_irq;
    end

    initial
    begin
        clint_pkg::word_t     got;
        clint_pkg::word_t     got2;
        clint_pkg::word_t     val;
        clint_pkg::axi_resp_e resp;
        logic [7:0]           strb;
        logic [15:0]          addr;
        logic [15:0]          bad_addr [6];
        logic [NUM_HARTS-1:0] irq_exp;
        longint unsigned      t0;
        int                   h;
        int                   n;

        lfsr_q   = 16'd94;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar_addr  = '0;
        r_ready  = 1'b0;
        for (int k = 0; k < NUM_HARTS; k++)
        begin
            cmp_model[k] = '1;
            pulse_cnt[k] = 0;
        end
        bad_addr = '{16'h0000, 16'h4010, 16'h4004, 16'hBFF0, 16'hBFFC, 16'hFFF8};

        n = 0;
        while (rst_n !== 1'b1)
        begin
            n++;
            if (n > 20)
                fail_now("reset was never released");
            @(posedge clk);
        end
        step();

        // reset values and a quiet interrupt line
        for (int k = 0; k < NUM_HARTS; k++)
        begin
            axi_read(clint_pkg::MTIMECMP_BASE + 16'(8 * k), got, resp);
            check_resp(resp, clint_pkg::AXI_OKAY, "mtimecmp reset read response");
            check_word(got, '1, "mtimecmp after reset");
        end
        repeat (50) step();
        check_irq(pulses_above(0), '0, "timer_irq pulses after reset");

        // random strobed writes, each read back against the model
        for (int i = 0; i < 12; i++)
        begin
            h    = int'(rand_bits(1));
            val  = rand_bits(64);
            strb = 8'(rand_bits(8));
            addr = clint_pkg::MTIMECMP_BASE + 16'(8 * h);
            axi_write(addr, val, strb, resp);
            check_resp(resp, clint_pkg::AXI_OKAY, "mtimecmp write response");
            cmp_model[h] = merge_bytes(cmp_model[h], val, strb);
            axi_read(addr, got, resp);
            check_resp(resp, clint_pkg::AXI_OKAY, "mtimecmp read response");
            check_word(got, cmp_model[h], "mtimecmp read-back");
        end

        // mtime write, then it keeps counting at the prescaled rate
        val = rand_bits(48);
        t0  = cyc;
        axi_write(clint_pkg::MTIME_OFFSET, val, 8'hFF, resp);
        check_resp(resp, clint_pkg::AXI_OKAY, "mtime write response");
        axi_read(clint_pkg::MTIME_OFFSET, got, resp);
        check_resp(resp, clint_pkg::AXI_OKAY, "mtime read response");
        check_range(got, val, val + (cyc - t0) / TICK_DIV + 1, "mtime after write");
        axi_read(clint_pkg::MTIME_OFFSET, got2, resp);
        check_range(got2, got, '1, "second mtime read");

        // unmapped offsets answer SLVERR and leave the registers alone
        axi_read(clint_pkg::MTIME_OFFSET, got, resp);
        foreach (bad_addr[i])
        begin
            axi_write(bad_addr[i], rand_bits(64), 8'hFF, resp);
            check_resp(resp, decode_ok(bad_addr[i]), "unmapped write response");
            axi_read(bad_addr[i], got2, resp);
            check_resp(resp, decode_ok(bad_addr[i]), "unmapped read response");
            check_word(got2, '0, "unmapped read data");
        end
        for (int k = 0; k < NUM_HARTS; k++)
        begin
            axi_read(clint_pkg::MTIMECMP_BASE + 16'(8 * k), got2, resp);
            check_word(got2, cmp_model[k], "mtimecmp after unmapped accesses");
        end
        axi_read(clint_pkg::MTIME_OFFSET, got2, resp);
        check_range(got2, got, '1, "mtime after unmapped accesses");

        // park both harts, then arm one deadline 20 ticks ahead
        for (int k = 0; k < NUM_HARTS; k++)
        begin
            axi_write(clint_pkg::MTIMECMP_BASE + 16'(8 * k), '1, 8'hFF, resp);
            cmp_model[k] = '1;
        end
        h = int'(rand_bits(1));
        repeat (4) step();
        for (int k = 0; k < NUM_HARTS; k++)
            pulse_cnt[k] = 0;
        axi_read(clint_pkg::MTIME_OFFSET, got, resp);
        val = got + 64'd20;
        axi_write(clint_pkg::MTIMECMP_BASE + 16'(8 * h), val, 8'hFF, resp);
        check_resp(resp, clint_pkg::AXI_OKAY, "mtimecmp deadline write response");
        n = 0;
        while (pulse_cnt[h] == 0)
        begin
            n++;
            if (n > TIMEOUT)
                fail_now($sformatf("timeout: no timer interrupt arrived for hart %0d", h));
            step();
        end
        repeat (10) step();
        irq_exp    = '0;
        irq_exp[h] = 1'b1;
        check_irq(pulses_above(0), irq_exp, "harts that saw a pulse");
        check_irq(pulses_above(1), '0, "harts that saw more than one pulse");
        axi_read(clint_pkg::MTIME_OFFSET, got2, resp);
        check_range(got2, val, '1, "mtime after the interrupt");

        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb/clint_tb_clock.sv
`timescale 1ns/1ps

module clint_tb_clock #(
    parameter int HALF_NS      = 2,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

    // release just after an edge so no flop sees it change at the edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule
